/* flist.f */
src/pi_pkg.sv
src/pi_req_stage.sv
src/dev_table.sv
src/scratch_ram.sv
src/pi_rsp_stage.sv
src/pi_subsys_top.sv
bench/tb_pi_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the peripheral bus testbench under Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_pi_subsys -Mdir "$BUILD_DIR" -o sim_tb -f flist.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! "./$BUILD_DIR/sim_tb" > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi

echo "Simulation finished cleanly"
exit 0

/* bench/tb_pi_subsys.sv */
// ==================================================
// Peripheral bus subsystem testbench
// ==================================================

`timescale 1ns/1ps

module tb_pi_subsys;

	import pi_pkg::*;

	localparam int DRAIN_MAX = 20;

	logic        clk_i = 1'b0;
	logic        rst_i;
	pi_req_s     req;
	pi_data_t    data_o;
	logic        valid_o;
	logic        rst0_o;
	logic        rst1_o;
	logic        rst2_o;

	logic [31:0] lfsr = 32'h3a3da3bf;
	int          ncyc = 0;
	int          err_cnt = 0;
	int          test_cnt = 0;
	int          test_fail = 0;
	pi_data_t    exp_q[$];
	int          cyc_q[$];

	// Reference model state
	pi_data_t    ram_m [0:RAM_WORDS-1];
	logic        r0_m = 1'b0;
	logic        r1_m = 1'b0;
	logic        preld_m = 1'b0;

	always #50 clk_i = ~clk_i;

	pi_subsys_top uut (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.req_i   (req),
		.data_o  (data_o),
		.valid_o (valid_o),
		.rst0_o  (rst0_o),
		.rst1_o  (rst1_o),
		.rst2_o  (rst2_o)
	);

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[31]};
		end
		return v;
	endfunction

	// Mostly the two windows with some unmapped space around them
	function automatic pi_addr_t pick_addr();
		logic [2:0] kind;
		kind = 3'(take_bits(3));
		if (kind < 3'd4) begin
			return RAM_BASE + pi_addr_t'(take_bits(6));
		end else if (kind < 3'd6) begin
			return pi_addr_t'(take_bits(4));
		end else if (kind == 3'd6) begin
			return 30'd16 + pi_addr_t'(take_bits(7));
		end
		return {1'b1, 29'(take_bits(29))};
	endfunction

	function automatic pi_req_s make_req(input pi_op_t op, input pi_addr_t addr,
			input pi_data_t data, input pi_sel_t sel);
		pi_req_s r;
		r.op   = op;
		r.addr = addr;
		r.data = data;
		r.sel  = sel;
		return r;
	endfunction

	// Returns the expected read word and advances the model state in issue order
	function automatic pi_data_t model_access(input pi_req_s r);
		pi_data_t          res;
		logic [RAM_AW-1:0] idx;
		res = '0;
		if (r.addr < DEVTBL_MAPSZ) begin
			if (r.op == OP_RD) begin
				case (r.addr)
					30'd0: res = ID_DEVTBL;
					30'd1: res = pi_data_t'(DEVTBL_MAPSZ) << 2;
					30'd2: res = ID_RAM;
					30'd3: res = (pi_data_t'(RAM_WORDS) << 2) | 32'd1;
					default: res = '0;
				endcase
			end else if (r.op == OP_RW && r.addr == 30'd0) begin
				case (r.data)
					32'd0: res = SOC_VERSION;
					32'd1: res = RAM_CACHE_SZ;
					32'd2: res = {30'd0, r1_m, r0_m};
					32'd3: res = preld_m ? 32'd0 : PRELDR_ADDR;
					default: res = '0;
				endcase
			end else if (r.op == OP_RW && r.addr == 30'd1) begin
				if (r.data < 32'd3) begin
					r0_m = (r.data != 32'd1);
					r1_m = (r.data != 32'd0);
				end else if (r.data == 32'd3) begin
					preld_m = 1'b1;
				end
			end
		end else if (r.addr >= RAM_BASE && r.addr < RAM_BASE + RAM_WORDS) begin
			idx = RAM_AW'(r.addr - RAM_BASE);
			res = ram_m[idx];
			if (r.op == OP_WR || r.op == OP_RW) begin
				for (int b = 0; b < 4; b++) begin
					if (r.sel[b]) begin
						ram_m[idx][8*b +: 8] = r.data[8*b +: 8];
					end
				end
			end
		end
		return res;
	endfunction

	task automatic check_data(input string name, input pi_data_t got, input pi_data_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_rst(input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: {rst2_o, rst1_o, rst0_o} = %b, expected %b",
				$time, got, exp);
			err_cnt++;
		end
	endtask

	// Read data is due on the fourth falling edge after the driving edge
	task automatic issue(input pi_req_s r);
		pi_data_t e;
		@(posedge clk_i);
		req <= r;
		e = model_access(r);
		if (r.op == OP_RD || r.op == OP_RW) begin
			exp_q.push_back(e);
			cyc_q.push_back(ncyc + 4);
		end
	endtask

	task automatic drain();
		int guard;
		issue(make_req(OP_NONE, '0, '0, '0));
		for (guard = 0; guard < DRAIN_MAX && exp_q.size() != 0; guard++) begin
			@(posedge clk_i);
		end
		if (exp_q.size() != 0) begin
			$display("Timed out at %0t with %0d reads still waiting for a valid pulse",
				$time, exp_q.size());
			err_cnt++;
			exp_q.delete();
			cyc_q.delete();
		end
	endtask

	// Levels hold until the device stage acts, then rst2 is high for one cycle only
	task automatic run_cmd(input pi_data_t c);
		logic [1:0] lvl;
		lvl = {r1_m, r0_m};
		issue(make_req(OP_RW, 30'd1, c, 4'hf));
		issue(make_req(OP_NONE, '0, '0, '0));
		@(negedge clk_i);
		check_rst({rst2_o, rst1_o, rst0_o}, {1'b0, lvl});
		@(negedge clk_i);
		check_rst({rst2_o, rst1_o, rst0_o}, {c == 32'd3, r1_m, r0_m});
		@(negedge clk_i);
		check_rst({rst2_o, rst1_o, rst0_o}, {1'b0, r1_m, r0_m});
	endtask

	task automatic end_test(input string name, input int err_before);
		test_cnt++;
		if (err_cnt == err_before) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			test_fail++;
			$display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
		end
	endtask

	always @(negedge clk_i) begin
		ncyc = ncyc + 1;
		if (valid_o === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("Valid pulse at %0t with no read pending", $time);
				err_cnt++;
			end else begin
				if (cyc_q[0] != ncyc) begin
					$display("Valid pulse at %0t came in cycle %0d instead of %0d",
						$time, ncyc, cyc_q[0]);
					err_cnt++;
				end
				check_data("data_o", data_o, exp_q[0]);
				void'(exp_q.pop_front());
				void'(cyc_q.pop_front());
			end
		end else if (exp_q.size() != 0 && cyc_q[0] <= ncyc) begin
			$display("Missing valid pulse at %0t for a pending read", $time);
			err_cnt++;
			void'(exp_q.pop_front());
			void'(cyc_q.pop_front());
		end
	end

	initial begin
		int       base;
		pi_addr_t a;
		pi_req_s  r;
		req   = '0;
		rst_i = 1'b1;
		repeat (10) @(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);
		check_rst({rst2_o, rst1_o, rst0_o}, 3'b000);

		base = err_cnt;
		for (int i = 0; i < 16; i++) begin
			issue(make_req(OP_RD, pi_addr_t'(i), take_bits(32), 4'hf));
		end
		drain();
		end_test("table reads", base);

		base = err_cnt;
		for (int q = 0; q < 4; q++) begin
			issue(make_req(OP_RW, '0, pi_data_t'(q), 4'hf));
		end
		issue(make_req(OP_RW, '0, 32'd4 + take_bits(16), 4'hf));
		drain();
		end_test("queries", base);

		base = err_cnt;
		run_cmd(32'd0);
		run_cmd(32'd1);
		run_cmd(32'd2);
		issue(make_req(OP_RW, '0, 32'd2, 4'hf));
		run_cmd(32'd3);
		issue(make_req(OP_RW, '0, 32'd3, 4'hf));
		drain();
		end_test("reset commands", base);

		// Fill every word first so no later read sees unknown contents
		base = err_cnt;
		for (int i = 0; i < 64; i++) begin
			issue(make_req(OP_WR, RAM_BASE + pi_addr_t'(i), take_bits(32), 4'hf));
		end
		for (int i = 0; i < 48; i++) begin
			a = RAM_BASE + pi_addr_t'(take_bits(6));
			issue(make_req(OP_WR, a, take_bits(32), pi_sel_t'(take_bits(4))));
		end
		for (int i = 0; i < 64; i++) begin
			issue(make_req(OP_RD, RAM_BASE + pi_addr_t'(i), '0, '0));
		end
		drain();
		end_test("ram byte writes", base);

		base = err_cnt;
		for (int i = 0; i < 48; i++) begin
			a = RAM_BASE + pi_addr_t'(take_bits(6));
			issue(make_req(OP_RW, a, take_bits(32), pi_sel_t'(take_bits(4))));
			if (take_bits(1) == 32'd1) begin
				issue(make_req(OP_RD, a, '0, '0));
			end
		end
		for (int i = 0; i < 64; i++) begin
			issue(make_req(OP_RD, RAM_BASE + pi_addr_t'(i), '0, '0));
		end
		drain();
		end_test("ram swaps", base);

		base = err_cnt;
		for (int i = 0; i < 16; i++) begin
			issue(make_req(OP_RD, 30'd16 + pi_addr_t'(take_bits(7)), '0, '0));
			issue(make_req(OP_WR, pi_addr_t'(take_bits(4)), take_bits(32), 4'hf));
			issue(make_req(OP_WR, {1'b1, 29'(take_bits(29))}, take_bits(32), 4'hf));
			issue(make_req(OP_RW, {1'b1, 29'(take_bits(29))}, take_bits(32), 4'hf));
		end
		for (int i = 0; i < 4; i++) begin
			issue(make_req(OP_RD, pi_addr_t'(i), '0, '0));
		end
		issue(make_req(OP_RW, '0, 32'd2, 4'hf));
		issue(make_req(OP_RW, '0, 32'd3, 4'hf));
		for (int i = 0; i < 64; i++) begin
			issue(make_req(OP_RD, RAM_BASE + pi_addr_t'(i), '0, '0));
		end
		drain();
		@(negedge clk_i);
		check_rst({rst2_o, rst1_o, rst0_o}, {1'b0, r1_m, r0_m});
		end_test("unmapped and ignored", base);

		base = err_cnt;
		for (int i = 0; i < 200; i++) begin
			r.op   = pi_op_t'(take_bits(2));
			r.addr = pick_addr();
			r.sel  = pi_sel_t'(take_bits(4));
			// Small values on the table so queries and commands get hit
			r.data = (r.addr < DEVTBL_MAPSZ) ? take_bits(3) : take_bits(32);
			if (r.op == OP_RW && r.addr == 30'd1) begin
				run_cmd(r.data);
			end else begin
				issue(r);
			end
		end
		drain();
		@(negedge clk_i);
		check_rst({rst2_o, rst1_o, rst0_o}, {1'b0, r1_m, r0_m});
		end_test("random mix", base);

		$display("Tests: %0d, failing tests: %0d, errors: %0d", test_cnt, test_fail, err_cnt);
		if (err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* src/pi_subsys_top.sv */
// ==================================================
// Peripheral bus subsystem top
// ==================================================

`timescale 1ns/1ps

module pi_subsys_top (
	input  logic             clk_i,
	input  logic             rst_i,
	input  pi_pkg::pi_req_s  req_i,
	output pi_pkg::pi_data_t data_o,
	output logic             valid_o,
	output logic             rst0_o,
	output logic             rst1_o,
	output logic             rst2_o
);

	import pi_pkg::*;

	dev_req_s dev_req;
	dev_rsp_s tbl_rsp;
	dev_rsp_s ram_rsp;

	pi_req_stage u_req_stage (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.req_i     (req_i),
		.dev_req_o (dev_req)
	);

	dev_table u_dev_table (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.dev_req_i (dev_req),
		.rsp_o     (tbl_rsp),
		.rst0_o    (rst0_o),
		.rst1_o    (rst1_o),
		.rst2_o    (rst2_o)
	);

	scratch_ram u_scratch_ram (
		.clk_i     (clk_i),
		.dev_req_i (dev_req),
		.rsp_o     (ram_rsp)
	);

	// Device select and op enter the response stage with the device answers
	pi_rsp_stage u_rsp_stage (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.tbl_rsp_i (tbl_rsp),
		.ram_rsp_i (ram_rsp),
		.dev_i     (dev_req.dev),
		.op_i      (dev_req.op),
		.data_o    (data_o),
		.valid_o   (valid_o)
	);

endmodule

/* src/pi_rsp_stage.sv */
// ==================================================
// Response merge stage
// ==================================================

`timescale 1ns/1ps

module pi_rsp_stage (
	input  logic             clk_i,
	input  logic             rst_i,
	input  pi_pkg::dev_rsp_s tbl_rsp_i,
	input  pi_pkg::dev_rsp_s ram_rsp_i,
	input  pi_pkg::dev_sel_t dev_i,
	input  pi_pkg::pi_op_t   op_i,
	output pi_pkg::pi_data_t data_o,
	output logic             valid_o
);

	import pi_pkg::*;

	dev_sel_t dev_q;
	pi_op_t   op_q;
	logic     is_rd;
	pi_data_t rd_data;

	// Track the operation while the device stage works on it
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			dev_q <= DEV_NONE;
			op_q  <= OP_NONE;
		end else begin
			dev_q <= dev_i;
			op_q  <= op_i;
		end
	end

	assign is_rd = (op_q == OP_RD) || (op_q == OP_RW);

	// Unmapped reads fall through to zero
	always_comb begin
		case (dev_q)
			DEV_TBL: rd_data = tbl_rsp_i.ack ? tbl_rsp_i.data : '0;
			DEV_RAM: rd_data = ram_rsp_i.ack ? ram_rsp_i.data : '0;
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (is_rd) begin
			data_o <= rd_data;
		end
		if (rst_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= is_rd;
		end
	end

endmodule

/* src/scratch_ram.sv */
// ==================================================
// Scratch RAM with byte selects
// ==================================================

`timescale 1ns/1ps

module scratch_ram (
	input  logic             clk_i,
	input  pi_pkg::dev_req_s dev_req_i,
	output pi_pkg::dev_rsp_s rsp_o
);

	import pi_pkg::*;

	pi_data_t          mem [0:RAM_WORDS-1];
	logic [RAM_AW-1:0] idx;
	logic              hit;
	logic              do_rd;
	logic              do_wr;

	assign idx = dev_req_i.offset[RAM_AW-1:0];
	assign hit = (dev_req_i.dev == DEV_RAM);

	// A read-write is a swap: old word out, new bytes in
	assign do_rd = hit && ((dev_req_i.op == OP_RD) || (dev_req_i.op == OP_RW));
	assign do_wr = hit && ((dev_req_i.op == OP_WR) || (dev_req_i.op == OP_RW));

	always_ff @(posedge clk_i) begin
		if (do_wr) begin
			for (int b = 0; b < $bits(pi_sel_t); b++) begin
				if (dev_req_i.sel[b]) begin
					mem[idx][8*b +: 8] <= dev_req_i.data[8*b +: 8];
				end
			end
		end
	end

	// The request stage holds OP_NONE during reset, which clears ack here
	always_ff @(posedge clk_i) begin
		rsp_o.ack <= do_rd;
		if (do_rd) begin
			rsp_o.data <= mem[idx];
		end
	end

endmodule

/* src/dev_table.sv */
// ==================================================
// Device table and system control
// ==================================================

`timescale 1ns/1ps

module dev_table (
	input  logic             clk_i,
	input  logic             rst_i,
	input  pi_pkg::dev_req_s dev_req_i,
	output pi_pkg::dev_rsp_s rsp_o,
	output logic             rst0_o,
	output logic             rst1_o,
	output logic             rst2_o
);

	import pi_pkg::*;

	logic     preld_done;
	logic     sel_rd;
	logic     sel_rw;
	pi_data_t enum_word;
	pi_data_t query_word;

	assign sel_rd = (dev_req_i.dev == DEV_TBL) && (dev_req_i.op == OP_RD);
	assign sel_rw = (dev_req_i.dev == DEV_TBL) && (dev_req_i.op == OP_RW);

	// Enumeration entries come in pairs of device id and map size
	// Bit 0 of the size word flags the RAM as memory
	always_comb begin
		case (dev_req_i.offset)
			30'd0: begin
				enum_word = ID_DEVTBL;
			end
			30'd1: begin
				enum_word = {DEVTBL_MAPSZ, 2'b00};
			end
			30'd2: begin
				enum_word = ID_RAM;
			end
			30'd3: begin
				enum_word = {RAM_WORDS, 2'b01};
			end
			default: begin
				enum_word = '0;
			end
		endcase
	end

	// Only offset 0 answers queries, command writes at offset 1 read zero
	always_comb begin
		query_word = '0;
		if (dev_req_i.offset == 30'd0) begin
			case (dev_req_i.data)
				32'd0: begin
					query_word = SOC_VERSION;
				end
				32'd1: begin
					query_word = RAM_CACHE_SZ;
				end
				32'd2: begin
					query_word = {30'd0, rst1_o, rst0_o};
				end
				32'd3: begin
					query_word = preld_done ? '0 : PRELDR_ADDR;
				end
				default: begin
					query_word = '0;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (sel_rd) begin
			rsp_o.data <= enum_word;
		end else if (sel_rw) begin
			rsp_o.data <= query_word;
		end

		if (rst_i) begin
			rsp_o.ack  <= 1'b0;
			rst0_o     <= 1'b0;
			rst1_o     <= 1'b0;
			rst2_o     <= 1'b0;
			preld_done <= 1'b0;
		end else begin
			rsp_o.ack <= sel_rd || sel_rw;
			// The third reset is a strobe, it drops on the next edge
			rst2_o    <= 1'b0;
			if (sel_rw && (dev_req_i.offset == 30'd1)) begin
				case (dev_req_i.data)
					32'd0: begin
						rst0_o <= 1'b1;
						rst1_o <= 1'b0;
					end
					32'd1: begin
						rst0_o <= 1'b0;
						rst1_o <= 1'b1;
					end
					32'd2: begin
						rst0_o <= 1'b1;
						rst1_o <= 1'b1;
					end
					32'd3: begin
						rst2_o     <= 1'b1;
						preld_done <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

/* src/pi_req_stage.sv */
// ==================================================
// Request stage and address decode
// ==================================================

`timescale 1ns/1ps

module pi_req_stage (
	input  logic             clk_i,
	input  logic             rst_i,
	input  pi_pkg::pi_req_s  req_i,
	output pi_pkg::dev_req_s dev_req_o
);

	import pi_pkg::*;

	localparam int AW = $bits(pi_addr_t);

	logic     in_tbl;
	logic     in_ram;
	dev_sel_t dev_nxt;
	pi_addr_t off_nxt;

	assign in_tbl = (req_i.addr < DEVTBL_MAPSZ);

	// The RAM window is aligned to its own size, so the upper bits identify it
	assign in_ram = (req_i.addr[AW-1:RAM_AW] == RAM_BASE[AW-1:RAM_AW]);

	always_comb begin
		dev_nxt = DEV_NONE;
		off_nxt = '0;
		if (req_i.op != OP_NONE) begin
			if (in_tbl) begin
				dev_nxt = DEV_TBL;
				off_nxt = req_i.addr;
			end else if (in_ram) begin
				dev_nxt = DEV_RAM;
				off_nxt = req_i.addr - RAM_BASE;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		dev_req_o.offset <= off_nxt;
		dev_req_o.data   <= req_i.data;
		dev_req_o.sel    <= req_i.sel;

		if (rst_i) begin
			dev_req_o.op  <= OP_NONE;
			dev_req_o.dev <= DEV_NONE;
		end else begin
			dev_req_o.op  <= req_i.op;
			dev_req_o.dev <= dev_nxt;
		end
	end

endmodule

/* src/pi_pkg.sv */
// ==================================================
// Peripheral bus shared definitions
// ==================================================

package pi_pkg;

	typedef logic [1:0]  pi_op_t;
	typedef logic [29:0] pi_addr_t;
	typedef logic [31:0] pi_data_t;
	typedef logic [3:0]  pi_sel_t;
	typedef logic [1:0]  dev_sel_t;

	localparam pi_op_t OP_NONE = 2'd0;
	localparam pi_op_t OP_WR   = 2'd1;
	localparam pi_op_t OP_RD   = 2'd2;
	localparam pi_op_t OP_RW   = 2'd3;

	localparam dev_sel_t DEV_NONE = 2'd0;
	localparam dev_sel_t DEV_TBL  = 2'd1;
	localparam dev_sel_t DEV_RAM  = 2'd2;

	// Address map, all sizes in words
	localparam pi_addr_t DEVTBL_MAPSZ = 30'd16;
	localparam pi_addr_t RAM_BASE     = 30'd256;
	localparam pi_addr_t RAM_WORDS    = 30'd64;
	localparam int       RAM_AW       = 6;

	localparam pi_data_t SOC_VERSION  = 32'h0001_0300;
	localparam pi_data_t RAM_CACHE_SZ = 32'd4096;
	localparam pi_data_t PRELDR_ADDR  = 32'h0000_8000;

	localparam pi_data_t ID_DEVTBL = 32'd7;
	localparam pi_data_t ID_RAM    = 32'd1;

	typedef struct packed {
		pi_op_t   op;
		pi_addr_t addr;
		pi_data_t data;
		pi_sel_t  sel;
	} pi_req_s;

	// Offset is relative to the start of the selected device window
	typedef struct packed {
		pi_op_t   op;
		dev_sel_t dev;
		pi_addr_t offset;
		pi_data_t data;
		pi_sel_t  sel;
	} dev_req_s;

	typedef struct packed {
		logic     ack;
		pi_data_t data;
	} dev_rsp_s;

endpackage
